// File: hdl/chanlink_defines.svh
`ifndef CHANLINK_DEFINES_SVH
`define CHANLINK_DEFINES_SVH

////////////////////////////////////////
// Widths and depths
`define CL_ADC_W       12
`define CL_WORD_W      16
`define CL_CRC_W       15
`define CL_EVT_DEPTH   256
`define CL_L1A_DEPTH   16
`define CL_OCC_W       5    // Holds 0 to CL_L1A_DEPTH
`define CL_SEQ_W       7

////////////////////////////////////////
// Frame layout
`define CL_DATA_WORDS  96   // 16 samples of 6 words
`define CL_HDR_A       16'hC4B4
`define CL_HDR_B       16'hC5B5
`define CL_TRL_MARK    16'h700C
`define CL_TRL_END     16'h7FFF
`define CL_PHASE_FIRST 72
`define CL_PHASE_LAST  77
`define CL_MODE_FIRST  90
`define CL_MODE_LAST   95

`endif

// File: hdl/chanlink_pkg.sv
`default_nettype none

`include "chanlink_defines.svh"

package chanlink_pkg;

	typedef struct packed {
		logic                 mlt_ovlp;
		logic                 ovlp;
		logic [3:0]           ocnt;     // Overlap count, not stored
		logic [`CL_ADC_W-1:0] adc;
	} evt_word_t;

	typedef struct packed {
		logic        phase;
		logic [11:0] mcnt;
		logic [23:0] l1a_cnt;
	} l1a_rec_t;

	// Two decodes of one 16-bit output word
	typedef struct packed {
		logic                 zero_hi;
		logic                 ovlp_n;
		logic                 serial;   // Phase or mode side bit
		logic                 zero_lo;
		logic [`CL_ADC_W-1:0] adc;
	} frame_data_t;

	typedef struct packed {
		logic [3:0]           code;
		logic [5:0]           l1a_lo;
		logic [`CL_OCC_W-1:0] occ;
		logic                 warn;
	} frame_status_t;

	typedef union packed {
		frame_data_t   data;
		frame_status_t status;
	} frame_word_u;

	// Parallel CRC-15, 13 data bits per step
	function automatic logic [`CL_CRC_W-1:0] crc15_d13(
		input logic [`CL_ADC_W:0]   d,
		input logic [`CL_CRC_W-1:0] c
	);
		logic [`CL_CRC_W-1:0] n;
		n[0]  = d[0] ^ c[2];
		n[1]  = d[0] ^ d[1] ^ c[2] ^ c[3];
		n[2]  = d[1] ^ d[2] ^ c[3] ^ c[4];
		n[3]  = d[2] ^ d[3] ^ c[4] ^ c[5];
		n[4]  = d[3] ^ d[4] ^ c[5] ^ c[6];
		n[5]  = d[4] ^ d[5] ^ c[6] ^ c[7];
		n[6]  = d[5] ^ d[6] ^ c[7] ^ c[8];
		n[7]  = d[6] ^ d[7] ^ c[8] ^ c[9];
		n[8]  = d[7] ^ d[8] ^ c[9] ^ c[10];
		n[9]  = d[8] ^ d[9] ^ c[10] ^ c[11];
		n[10] = d[9] ^ d[10] ^ c[11] ^ c[12];
		n[11] = d[10] ^ d[11] ^ c[12] ^ c[13];
		n[12] = d[11] ^ d[12] ^ c[13] ^ c[14];
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage

`default_nettype wire

// File: hdl/evt_word_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "chanlink_defines.svh"

module evt_word_buffer (
	input  wire                          RCLK,
	input  wire                          RST_RESYNC,
	input  wire                          evt_wr_i,
	input  wire chanlink_pkg::evt_word_t evt_data_i,
	input  wire                          evt_rd_i,
	output logic                         evt_ready_o,
	output chanlink_pkg::evt_word_t      evt_head_o
);
	import chanlink_pkg::*;

	localparam int PTR_W = $clog2(`CL_EVT_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	localparam int ENT_W = `CL_ADC_W + 2;   // Two flags and the ADC value

	localparam logic [CNT_W-1:0] CNT_FULL  = CNT_W'(`CL_EVT_DEPTH);
	localparam logic [CNT_W-1:0] CNT_READY = CNT_W'(`CL_DATA_WORDS);

	logic [ENT_W-1:0] mem [`CL_EVT_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic [ENT_W-1:0] head_ent;
	logic             wr_ok;
	logic             rd_ok;

	assign wr_ok = evt_wr_i && (fill != CNT_FULL);   // Drop when full
	assign rd_ok = evt_rd_i && (fill != '0);

	////////////////////////////////////////
	// Storage

	always_ff @(posedge RCLK) begin
		if (wr_ok) begin
			mem[wr_ptr] <= {evt_data_i.mlt_ovlp, evt_data_i.ovlp, evt_data_i.adc};
		end
	end

	////////////////////////////////////////
	// Pointers and fill count

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_ok, rd_ok})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	////////////////////////////////////////
	// Head word and ready level

	assign head_ent = mem[rd_ptr];   // Fall-through read

	always_comb begin
		evt_head_o.mlt_ovlp = head_ent[ENT_W-1];
		evt_head_o.ovlp     = head_ent[ENT_W-2];
		evt_head_o.ocnt     = '0;
		evt_head_o.adc      = head_ent[`CL_ADC_W-1:0];
	end

	// One full event stored
	assign evt_ready_o = (fill >= CNT_READY);

endmodule

`default_nettype wire

// File: hdl/l1a_record_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "chanlink_defines.svh"

module l1a_record_buffer (
	input  wire                         RCLK,
	input  wire                         RST_RESYNC,
	input  wire                         l1a_wr_i,
	input  wire chanlink_pkg::l1a_rec_t l1a_data_i,
	input  wire                         l1a_pop_i,
	output logic                        l1a_avail_o,
	output chanlink_pkg::l1a_rec_t      l1a_head_o,
	output logic [`CL_OCC_W-1:0]        occupancy_o
);
	import chanlink_pkg::*;

	localparam int PTR_W = $clog2(`CL_L1A_DEPTH);

	localparam logic [`CL_OCC_W-1:0] OCC_FULL = `CL_OCC_W'(`CL_L1A_DEPTH);

	l1a_rec_t             mem [`CL_L1A_DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [`CL_OCC_W-1:0] occ;
	logic                 wr_ok;
	logic                 pop_ok;

	assign wr_ok  = l1a_wr_i && (occ != OCC_FULL);
	assign pop_ok = l1a_pop_i && (occ != '0);

	always_ff @(posedge RCLK) begin
		if (wr_ok) begin
			mem[wr_ptr] <= l1a_data_i;
		end
	end

	////////////////////////////////////////
	// Pointers and up/down occupancy

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ    <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_ok, pop_ok})
				2'b10: occ <= occ + 1'b1;
				2'b01: occ <= occ - 1'b1;
				default: occ <= occ;   // Write and pop together
			endcase
		end
	end

	assign l1a_head_o  = mem[rd_ptr];   // Fall-through read
	assign l1a_avail_o = (occ != '0);
	assign occupancy_o = occ;

endmodule

`default_nettype wire

// File: hdl/frame_assembler.sv
`timescale 1ns/1ns
`default_nettype none

`include "chanlink_defines.svh"

module frame_assembler (
	input  wire                          RCLK,
	input  wire                          RST_RESYNC,
	input  wire                          evt_ready_i,
	input  wire chanlink_pkg::evt_word_t evt_head_i,
	output logic                         evt_rd_o,
	input  wire                          l1a_avail_i,
	input  wire chanlink_pkg::l1a_rec_t  l1a_head_i,
	input  wire [`CL_OCC_W-1:0]          occupancy_i,
	output logic                         l1a_pop_o,
	input  wire                          warn_i,
	output logic [`CL_WORD_W-1:0]        dout_o,
	output logic                         dvalid_o,
	output logic                         last_wrd_o,
	output logic                         ovlp_mux_o,
	output logic                         mlt_ovlp_o
);
	import chanlink_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HDR,
		ST_DATA,
		ST_TRL
	} state_t;

	// Header positions
	localparam logic [`CL_SEQ_W-1:0] SEQ_HDR_A  = `CL_SEQ_W'(0);
	localparam logic [`CL_SEQ_W-1:0] SEQ_CNT_LO = `CL_SEQ_W'(1);
	localparam logic [`CL_SEQ_W-1:0] SEQ_CNT_HI = `CL_SEQ_W'(2);
	localparam logic [`CL_SEQ_W-1:0] SEQ_HDR_B  = `CL_SEQ_W'(3);

	// Data and trailer positions, trailer follows on from the data count
	localparam logic [`CL_SEQ_W-1:0] DATA_LAST  = `CL_SEQ_W'(`CL_DATA_WORDS - 1);
	localparam logic [`CL_SEQ_W-1:0] TRL_CRC    = `CL_SEQ_W'(`CL_DATA_WORDS);
	localparam logic [`CL_SEQ_W-1:0] TRL_MARK   = `CL_SEQ_W'(`CL_DATA_WORDS + 1);
	localparam logic [`CL_SEQ_W-1:0] TRL_STAT   = `CL_SEQ_W'(`CL_DATA_WORDS + 2);
	localparam logic [`CL_SEQ_W-1:0] TRL_END    = `CL_SEQ_W'(`CL_DATA_WORDS + 3);

	localparam logic [`CL_SEQ_W-1:0] PHASE_FIRST = `CL_SEQ_W'(`CL_PHASE_FIRST);
	localparam logic [`CL_SEQ_W-1:0] PHASE_LAST  = `CL_SEQ_W'(`CL_PHASE_LAST);
	localparam logic [`CL_SEQ_W-1:0] MODE_FIRST  = `CL_SEQ_W'(`CL_MODE_FIRST);
	localparam logic [`CL_SEQ_W-1:0] MODE_LAST   = `CL_SEQ_W'(`CL_MODE_LAST);

	localparam logic [3:0] STATUS_CODE = 4'h7;

	state_t               state_q;
	logic [`CL_SEQ_W-1:0] seq_q;
	logic [`CL_CRC_W-1:0] crc_q;
	logic                 start;
	logic                 serial;
	frame_word_u          word_d;

	assign start     = (state_q == ST_IDLE) && evt_ready_i && l1a_avail_i;
	assign evt_rd_o  = (state_q == ST_DATA);   // One pop per data word
	assign l1a_pop_o = (state_q == ST_TRL) && (seq_q == TRL_END);

	////////////////////////////////////////
	// Frame sequencer

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state_q <= ST_IDLE;
			seq_q   <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (start) begin
						state_q <= ST_HDR;
					end
				end
				ST_HDR: begin
					if (seq_q == SEQ_HDR_B) begin
						state_q <= ST_DATA;
						seq_q   <= '0;
					end else begin
						seq_q <= seq_q + 1'b1;
					end
				end
				ST_DATA: begin
					seq_q <= seq_q + 1'b1;
					if (seq_q == DATA_LAST) begin
						state_q <= ST_TRL;
					end
				end
				default: begin
					if (seq_q == TRL_END) begin
						state_q <= ST_IDLE;   // At least one idle cycle
						seq_q   <= '0;
					end else begin
						seq_q <= seq_q + 1'b1;
					end
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Word builder

	always_comb begin
		if (seq_q inside {[PHASE_FIRST:PHASE_LAST]}) begin
			serial = l1a_head_i.phase;
		end else if (seq_q inside {[MODE_FIRST:MODE_LAST]}) begin
			serial = 1'b1;   // 16-sample mode
		end else begin
			serial = 1'b0;
		end
	end

	always_comb begin
		word_d = '0;
		case (state_q)
			ST_HDR: begin
				case (seq_q)
					SEQ_HDR_A: word_d = `CL_HDR_A;
					SEQ_CNT_LO: word_d = {4'h0, l1a_head_i.l1a_cnt[11:0]};
					SEQ_CNT_HI: word_d = {4'h0, l1a_head_i.l1a_cnt[23:12]};
					default: word_d = `CL_HDR_B;
				endcase
			end
			ST_DATA: begin
				word_d.data.zero_hi = 1'b0;
				word_d.data.ovlp_n  = ~evt_head_i.ovlp;
				word_d.data.serial  = serial;
				word_d.data.zero_lo = 1'b0;
				word_d.data.adc     = evt_head_i.adc;
			end
			ST_TRL: begin
				case (seq_q)
					TRL_CRC: word_d = {1'b0, crc_q};
					TRL_MARK: word_d = `CL_TRL_MARK;
					TRL_STAT: begin
						word_d.status.code   = STATUS_CODE;
						word_d.status.l1a_lo = l1a_head_i.l1a_cnt[5:0];
						word_d.status.occ    = occupancy_i;   // Current record still held
						word_d.status.warn   = warn_i;
					end
					default: word_d = `CL_TRL_END;
				endcase
			end
			default: word_d = '0;
		endcase
	end

	// CRC over the 96 data words
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			crc_q <= '0;
		end else if (state_q == ST_HDR) begin
			crc_q <= '0;
		end else if (state_q == ST_DATA) begin
			crc_q <= crc15_d13({1'b0, evt_head_i.adc}, crc_q);
		end
	end

	////////////////////////////////////////
	// Output registers

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			dvalid_o   <= 1'b0;
			last_wrd_o <= 1'b0;
			ovlp_mux_o <= 1'b0;
			mlt_ovlp_o <= 1'b0;
		end else begin
			dvalid_o   <= (state_q != ST_IDLE);
			last_wrd_o <= l1a_pop_o;
			if (state_q == ST_DATA) begin
				ovlp_mux_o <= ~evt_head_i.ovlp;
				mlt_ovlp_o <= evt_head_i.mlt_ovlp;
			end else begin
				mlt_ovlp_o <= 1'b0;   // Mux value held
			end
		end
	end

	always_ff @(posedge RCLK) begin
		dout_o <= word_d;
	end

endmodule

`default_nettype wire

// File: hdl/chanlink_readout.sv
`timescale 1ns/1ns
`default_nettype none

`include "chanlink_defines.svh"

module chanlink_readout (
	input  wire                          RCLK,
	input  wire                          RST_RESYNC,
	input  wire                          evt_wr_i,
	input  wire chanlink_pkg::evt_word_t evt_data_i,
	input  wire                          l1a_wr_i,
	input  wire chanlink_pkg::l1a_rec_t  l1a_data_i,
	input  wire                          warn_i,
	output logic [`CL_WORD_W-1:0]        dout_o,
	output logic                         dvalid_o,
	output logic                         last_wrd_o,
	output logic                         ovlp_mux_o,
	output logic                         mlt_ovlp_o
);
	import chanlink_pkg::*;

	evt_word_t            evt_head;
	l1a_rec_t             l1a_head;
	logic [`CL_OCC_W-1:0] occupancy;
	logic                 evt_ready;
	logic                 evt_rd;
	logic                 l1a_avail;
	logic                 l1a_pop;

	evt_word_buffer i_evt_buf (
		.RCLK        (RCLK),
		.RST_RESYNC  (RST_RESYNC),
		.evt_wr_i    (evt_wr_i),
		.evt_data_i  (evt_data_i),
		.evt_rd_i    (evt_rd),
		.evt_ready_o (evt_ready),
		.evt_head_o  (evt_head)
	);

	l1a_record_buffer i_l1a_buf (
		.RCLK        (RCLK),
		.RST_RESYNC  (RST_RESYNC),
		.l1a_wr_i    (l1a_wr_i),
		.l1a_data_i  (l1a_data_i),
		.l1a_pop_i   (l1a_pop),
		.l1a_avail_o (l1a_avail),
		.l1a_head_o  (l1a_head),
		.occupancy_o (occupancy)
	);

	frame_assembler i_frame (
		.RCLK        (RCLK),
		.RST_RESYNC  (RST_RESYNC),
		.evt_ready_i (evt_ready),
		.evt_head_i  (evt_head),
		.evt_rd_o    (evt_rd),
		.l1a_avail_i (l1a_avail),
		.l1a_head_i  (l1a_head),
		.occupancy_i (occupancy),
		.l1a_pop_o   (l1a_pop),
		.warn_i      (warn_i),
		.dout_o      (dout_o),
		.dvalid_o    (dvalid_o),
		.last_wrd_o  (last_wrd_o),
		.ovlp_mux_o  (ovlp_mux_o),
		.mlt_ovlp_o  (mlt_ovlp_o)
	);

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic RCLK,
	output logic RST_RESYNC
);

	// 4 ns period
	initial begin
		RCLK = 1'b0;
		forever #2 RCLK = ~RCLK;
	end

	initial begin
		RST_RESYNC = 1'b0;
		#1 RST_RESYNC = 1'b1;   // Edge for the async reset
		repeat (8) @(posedge RCLK);
		#1 RST_RESYNC = 1'b0;
	end

endmodule

`default_nettype wire

// File: test/tb_chanlink_readout.sv
`timescale 1ns/1ns
`default_nettype none

`include "chanlink_defines.svh"

module tb_chanlink_readout;
	import chanlink_pkg::*;

	localparam int          FRAME_WORDS = 104;
	localparam int          BURSTS      = 12;
	localparam int          TIMEOUT     = 4000;
	localparam logic [31:0] LFSR_SEED   = 32'h49a2_2210;
	localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

	logic                  RCLK;
	logic                  RST_RESYNC;
	logic                  evt_wr;
	evt_word_t             evt_data;
	logic                  l1a_wr;
	l1a_rec_t              l1a_data;
	logic                  warn;
	logic [`CL_WORD_W-1:0] dout;
	logic                  dvalid;
	logic                  last_wrd;
	logic                  ovlp_mux;
	logic                  mlt_ovlp;

	logic [31:0] lfsr;
	evt_word_t   evt_q[$];   // Words written, oldest first
	l1a_rec_t    l1a_q[$];
	int          frames_done;
	int          errors;
	logic        ovlp_mux_model;

	tb_clock_gen i_clk (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC)
	);

	chanlink_readout i_dut (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.evt_wr_i   (evt_wr),
		.evt_data_i (evt_data),
		.l1a_wr_i   (l1a_wr),
		.l1a_data_i (l1a_data),
		.warn_i     (warn),
		.dout_o     (dout),
		.dvalid_o   (dvalid),
		.last_wrd_o (last_wrd),
		.ovlp_mux_o (ovlp_mux),
		.mlt_ovlp_o (mlt_ovlp)
	);

	////////////////////////////////////////
	// Random bits and CRC model

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);   // Galois step
		end
		return v;
	endfunction

	function automatic logic [14:0] model_crc(input logic [12:0] d, input logic [14:0] c);
		logic [14:0] n;
		n[0] = d[0] ^ c[2];
		for (int i = 1; i <= 12; i++) begin
			n[i] = d[i-1] ^ d[i] ^ c[i+1] ^ c[i+2];
		end
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

	////////////////////////////////////////
	// Checks

	task automatic compare_word(input string name, input logic [15:0] want,
			input logic [15:0] got);
		assert (got === want) else begin
			errors++;
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, want, got);
			$display("sim failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic compare_bit(input string name, input logic want, input logic got);
		assert (got === want) else begin
			errors++;
			$display("FAILED at %0t ns: %s expected %b, got %b", $time, name, want, got);
			$display("sim failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic stop_on_fault(input string what);
		errors++;
		$display("%0t ns: %s", $time, what);
		$display("sim failed");
		$fatal(1, "stopped on fault");
	endtask

	task automatic wait_reset_release();
		int n;
		for (n = 0; n < TIMEOUT && RST_RESYNC !== 1'b1; n++) begin
			@(negedge RCLK);
		end
		assert (RST_RESYNC === 1'b1) else stop_on_fault("reset was never asserted");
		for (n = 0; n < TIMEOUT && RST_RESYNC !== 1'b0; n++) begin
			@(negedge RCLK);
		end
		assert (RST_RESYNC === 1'b0) else stop_on_fault("reset was never released");
	endtask

	task automatic wait_dvalid_high();
		int n;
		for (n = 0; n < TIMEOUT && dvalid !== 1'b1; n++) begin
			compare_bit("last_wrd_o", 1'b0, last_wrd);
			compare_bit("ovlp_mux_o", ovlp_mux_model, ovlp_mux);   // Held while idle
			@(negedge RCLK);
		end
		assert (dvalid === 1'b1) else stop_on_fault("timeout waiting for DVALID to rise");
	endtask

	task automatic check_frame();
		l1a_rec_t    rec;
		evt_word_t   w;
		frame_word_u want;
		logic [14:0] crc;
		int          k;
		assert (l1a_q.size() > 0 && evt_q.size() >= `CL_DATA_WORDS) else
			stop_on_fault("DVALID rose before an event and an L1A record were stored");
		rec = l1a_q[0];
		crc = '0;
		for (int i = 0; i < FRAME_WORDS; i++) begin
			want = '0;
			compare_bit("dvalid_o", 1'b1, dvalid);
			if (i == 0) begin
				want = `CL_HDR_A;
			end else if (i == 1) begin
				want = {4'h0, rec.l1a_cnt[11:0]};
			end else if (i == 2) begin
				want = {4'h0, rec.l1a_cnt[23:12]};
			end else if (i == 3) begin
				want = `CL_HDR_B;
			end else if (i < 4 + `CL_DATA_WORDS) begin
				k = i - 4;
				w = evt_q.pop_front();
				want.data.ovlp_n = ~w.ovlp;
				want.data.adc    = w.adc;
				if (k >= `CL_PHASE_FIRST && k <= `CL_PHASE_LAST) begin
					want.data.serial = rec.phase;
				end else if (k >= `CL_MODE_FIRST && k <= `CL_MODE_LAST) begin
					want.data.serial = 1'b1;
				end
				crc            = model_crc({1'b0, w.adc}, crc);
				ovlp_mux_model = ~w.ovlp;
				compare_bit("mlt_ovlp_o", w.mlt_ovlp, mlt_ovlp);
			end else if (i == 4 + `CL_DATA_WORDS) begin
				want = {1'b0, crc};
			end else if (i == 5 + `CL_DATA_WORDS) begin
				want = `CL_TRL_MARK;
			end else if (i == 6 + `CL_DATA_WORDS) begin
				want.status.code   = 4'h7;
				want.status.l1a_lo = rec.l1a_cnt[5:0];
				want.status.occ    = 5'(l1a_q.size());   // Current record included
				want.status.warn   = warn;
			end else begin
				want = `CL_TRL_END;
			end
			compare_word("dout_o", want, dout);
			compare_bit("ovlp_mux_o", ovlp_mux_model, ovlp_mux);
			compare_bit("last_wrd_o", i == FRAME_WORDS - 1, last_wrd);
			@(negedge RCLK);
		end
		compare_bit("dvalid_o", 1'b0, dvalid);   // Idle gap after frame
		void'(l1a_q.pop_front());
		frames_done++;
	endtask

	////////////////////////////////////////
	// Stimulus

	task automatic next_cycle();
		@(posedge RCLK);
		#1;
	endtask

	task automatic put_word(input int gap_bits);
		evt_word_t w;
		int        gap;
		w.mlt_ovlp = 1'(rand_bits(1));
		w.ovlp     = 1'(rand_bits(1));
		w.ocnt     = 4'(rand_bits(4));
		w.adc      = 12'(rand_bits(12));
		gap        = int'(rand_bits(gap_bits));
		evt_q.push_back(w);
		evt_wr   = 1'b1;
		evt_data = w;
		next_cycle();
		evt_wr = 1'b0;
		repeat (gap) next_cycle();
	endtask

	task automatic put_record();
		l1a_rec_t r;
		int       gap;
		r.phase   = 1'(rand_bits(1));
		r.mcnt    = 12'(rand_bits(12));
		r.l1a_cnt = 24'(rand_bits(24));
		gap       = int'(rand_bits(2));
		l1a_q.push_back(r);
		l1a_wr   = 1'b1;
		l1a_data = r;
		next_cycle();
		l1a_wr = 1'b0;
		repeat (gap) next_cycle();
	endtask

	task automatic wait_frames(input int target);
		int n;
		for (n = 0; n < TIMEOUT && frames_done < target; n++) begin
			next_cycle();
		end
		assert (frames_done == target) else
			stop_on_fault("frame count did not match the number of stored events");
	endtask

	// Output checker
	initial begin
		wait_reset_release();
		@(negedge RCLK);
		compare_bit("dvalid_o", 1'b0, dvalid);
		compare_bit("last_wrd_o", 1'b0, last_wrd);
		compare_bit("ovlp_mux_o", 1'b0, ovlp_mux);
		compare_bit("mlt_ovlp_o", 1'b0, mlt_ovlp);
		forever begin
			wait_dvalid_high();
			check_frame();
		end
	end

	initial begin
		int n_evt;
		int gap_bits;
		int issued;
		evt_wr         = 1'b0;
		evt_data       = '0;
		l1a_wr         = 1'b0;
		l1a_data       = '0;
		warn           = 1'b0;
		lfsr           = LFSR_SEED;
		errors         = 0;
		frames_done    = 0;
		ovlp_mux_model = 1'b0;
		issued         = 0;
		wait_reset_release();
		next_cycle();

		// Words alone must not start a frame
		warn = 1'(rand_bits(1));
		repeat (`CL_DATA_WORDS) put_word(2);
		repeat (12) begin
			next_cycle();
			compare_bit("dvalid_o", 1'b0, dvalid);
		end
		put_record();
		issued = 1;
		wait_frames(issued);

		for (int b = 1; b < BURSTS; b++) begin
			n_evt    = 1 + int'(rand_bits(1));
			gap_bits = rand_bits(1) ? 0 : 2;   // Dense bursts give back-to-back frames
			warn     = 1'(rand_bits(1));
			repeat (n_evt) put_record();
			repeat (n_evt * `CL_DATA_WORDS) put_word(gap_bits);
			issued += n_evt;
			wait_frames(issued);
		end

		compare_word("words left in model", 16'h0, 16'(evt_q.size()));
		if (errors == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "errors found");
		end
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/chanlink_pkg.sv
hdl/evt_word_buffer.sv
hdl/l1a_record_buffer.sv
hdl/frame_assembler.sv
hdl/chanlink_readout.sv
test/tb_clock_gen.sv
test/tb_chanlink_readout.sv

// File: Makefile
SIM  := obj_dir/Vtb_chanlink_readout
SRCS := $(wildcard hdl/*.sv hdl/*.svh test/*.sv)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): src.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f src.f --top-module tb_chanlink_readout \
		-Mdir obj_dir -o Vtb_chanlink_readout

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
